// File: xbus_subsys.f
src/xbus_pkg.sv
src/xbus_scratch_mem.sv
src/xbus_arbiter.sv
src/xbus_slave_port.sv
src/xbus_reg_file.sv
src/xbus_subsys.sv
dv/xbus_subsys_assertions.sv
dv/xbus_subsys_tb.sv

// File: Bender.yml
package:
  name: xbus_subsys

sources:
  - src/xbus_pkg.sv
  - src/xbus_scratch_mem.sv
  - src/xbus_arbiter.sv
  - src/xbus_slave_port.sv
  - src/xbus_reg_file.sv
  - src/xbus_subsys.sv
  - target: test
    files:
      - dv/xbus_subsys_assertions.sv
      - dv/xbus_subsys_tb.sv

// File: dv/xbus_subsys_tb.sv
/* Testbench for the xbus slave subsystem. Plays both bus masters, keeps a
   model of every register and checks read data, grants and slot timing. */
`timescale 1ns/1ps

module xbus_subsys_tb;

  import xbus_pkg::*;

  localparam int half_period   = 20;
  localparam int reset_cycles  = 8;
  // 79 transfers in the sequence below, about 3 cycles each
  localparam int num_transfers = 80;
  localparam int margin_cycles = 60;

  logic        xbus_clock;
  logic        xbus_reset;
  logic [1:0]  request;
  logic [15:0] addr;
  logic        read;
  logic        write;
  logic        bip;
  logic [7:0]  data_w;
  logic        start;
  logic [1:0]  grant;
  logic [7:0]  data_r;
  logic        data_oe;
  logic        slave_wait;
  logic        error;

  int seed = 70492;
  int data_errors = 0;
  int arb_errors = 0;
  int timing_errors = 0;
  int resp_errors = 0;
  int bound_errors = 0;
  int cycle_count = 0;
  int prev_start_cycle = 0;
  int last_gap = 0;

  // Register model
  logic [7:0] model_addr_reg;
  logic [7:0] model_config;
  logic [7:0] model_user;
  logic [7:0] model_ind [num_indirect];
  logic [7:0] model_rw [num_block_regs];
  logic [7:0] model_mem [256];
  logic [7:0] mem_ofs [8];
  logic [7:0] idx_a;
  logic [7:0] idx_b;

  xbus_subsys dut_i (
    .xbus_clock (xbus_clock),
    .xbus_reset (xbus_reset),
    .request    (request),
    .addr       (addr),
    .read       (read),
    .write      (write),
    .bip        (bip),
    .data_w     (data_w),
    .start      (start),
    .grant      (grant),
    .data_r     (data_r),
    .data_oe    (data_oe),
    .slave_wait (slave_wait),
    .error      (error)
  );

  always #half_period xbus_clock = ~xbus_clock;

  always @(posedge xbus_clock) begin
    cycle_count <= cycle_count + 1;
  end

  // ----------------------------------------------------------------------
  // Model of the register map
  // ----------------------------------------------------------------------
  function automatic logic [15:0] reg_addr(input logic [7:0] ofs);
    return {reg_base[15:8], ofs};
  endfunction

  function automatic bit in_block(input logic [7:0] ofs, input logic [7:0] base);
    return int'(ofs) >= int'(base) && int'(ofs) < int'(base) + num_block_regs;
  endfunction

  function automatic logic [7:0] expected_read(input logic [15:0] a);
    if (a[15:8] == mem_base[15:8]) begin
      return model_mem[a[7:0]];
    end
    if (a[15:8] != reg_base[15:8]) begin
      return 8'h00;
    end
    case (a[7:0])
      ofs_addr_reg: return model_addr_reg;
      ofs_config:   return model_config;
      ofs_user:     return model_user;
      ofs_shared:   return rst_shared_rd;
      ofs_indirect: return model_ind[model_addr_reg[2:0]];
      default: ;
    endcase
    if (in_block(a[7:0], ofs_rw_block)) begin
      return model_rw[a[1:0]];
    end
    if (in_block(a[7:0], ofs_ro_block)) begin
      return rst_ro;
    end
    // WO block and holes in the window
    return 8'h00;
  endfunction

  function automatic void model_write(input logic [15:0] a, input logic [7:0] d);
    if (a[15:8] == mem_base[15:8]) begin
      model_mem[a[7:0]] = d;
    end else if (a[15:8] == reg_base[15:8]) begin
      case (a[7:0])
        ofs_addr_reg: model_addr_reg = d;
        ofs_config:   model_config = d;
        ofs_user:     model_user = model_user + 8'd1;
        ofs_indirect: model_ind[model_addr_reg[2:0]] = d;
        default: ;
      endcase
      if (in_block(a[7:0], ofs_rw_block)) begin
        model_rw[a[1:0]] = d;
      end
    end
  endfunction

  task automatic check_timing(input bit ok, input string what);
    assert (ok) else begin
      timing_errors++;
      $display("CHECK FAILED at %0t: %s", $time, what);
    end
  endtask

  // ----------------------------------------------------------------------
  // Bus master, entered and left just after a rising edge
  // ----------------------------------------------------------------------
  task automatic bus_transfer(input logic [1:0] req, input bit is_wr,
                              input logic [15:0] a, input logic [7:0] d, input int extra);
    logic [1:0] want;
    logic [7:0] exp;
    want = req[0] ? 2'b01 : 2'b10;
    exp = expected_read(a);
    request <= req;
    do begin
      @(negedge xbus_clock);
    end while (!start);
    last_gap = cycle_count - prev_start_cycle;
    prev_start_cycle = cycle_count;
    @(posedge xbus_clock);
    assert (grant == want) else begin
      arb_errors++;
      $display("CHECK FAILED at %0t: request %b gave grant %b, expected %b",
               $time, req, grant, want);
    end
    request <= 2'b00;
    addr <= a;
    read <= !is_wr;
    write <= is_wr;
    @(posedge xbus_clock);
    read <= 1'b0;
    write <= 1'b0;
    for (int k = 0; k <= extra; k++) begin
      bip <= (k < extra);
      data_w <= is_wr ? d : 8'h00;
      @(negedge xbus_clock);
      // The slave never stalls and never signals an error
      assert (!slave_wait && !error) else begin
        resp_errors++;
        $display("CHECK FAILED at %0t: wait %b error %b in the data phase of %h",
                 $time, slave_wait, error, a);
      end
      if (!is_wr && k == 0) begin
        assert (data_oe && data_r == exp) else begin
          data_errors++;
          $display("CHECK FAILED at %0t: read of %h gave %h with oe %b, expected %h",
                   $time, a, data_r, data_oe, exp);
        end
      end
      @(posedge xbus_clock);
    end
    bip <= 1'b0;
    data_w <= 8'h00;
    if (is_wr) begin
      model_write(a, d);
    end
  endtask

  task automatic write_bus(input logic [15:0] a, input logic [7:0] d);
    bus_transfer(2'b01, 1'b1, a, d, 0);
  endtask

  task automatic read_bus(input logic [15:0] a);
    bus_transfer(2'b10, 1'b0, a, 8'h00, 0);
  endtask

  task automatic check_idle_starts(input int n);
    request <= 2'b00;
    do begin
      @(negedge xbus_clock);
    end while (!start);
    for (int i = 1; i <= n; i++) begin
      @(negedge xbus_clock);
      check_timing(start == (i % 2 == 0), "start not every second cycle while idle");
    end
    @(posedge xbus_clock);
  endtask

  // Stops a hung run
  initial begin
    #((reset_cycles + num_transfers * 3 + margin_cycles) * 2 * half_period);
    $display("Timeout: the bus transfers did not complete in the expected time");
    $display("Testbench failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    xbus_clock = 1'b0;
    xbus_reset = 1'b1;
    request = 2'b00;
    addr = 16'h0000;
    read = 1'b0;
    write = 1'b0;
    bip = 1'b0;
    data_w = 8'h00;
    model_addr_reg = rst_addr_reg;
    model_config = rst_config;
    model_user = 8'h00;
    for (int i = 0; i < num_indirect; i++) begin
      model_ind[i] = 8'h00;
    end
    for (int i = 0; i < num_block_regs; i++) begin
      model_rw[i] = rst_rw;
    end
    repeat (reset_cycles) @(posedge xbus_clock);
    xbus_reset <= 1'b0;

    // Reset values, first start one cycle after release
    @(negedge xbus_clock);
    check_timing(!start, "start high in the cycle of reset release");
    @(negedge xbus_clock);
    check_timing(start, "no start one cycle after reset release");
    @(posedge xbus_clock);
    read_bus(reg_addr(ofs_addr_reg));
    read_bus(reg_addr(ofs_config));
    read_bus(reg_addr(ofs_shared));
    for (int i = 0; i < num_block_regs; i++) begin
      read_bus(reg_addr(ofs_rw_block + 8'(i)));
      read_bus(reg_addr(ofs_ro_block + 8'(i)));
      read_bus(reg_addr(ofs_wo_block + 8'(i)));
    end

    // Access policies of each region
    for (int i = 0; i < num_block_regs; i++) begin
      write_bus(reg_addr(ofs_rw_block + 8'(i)), 8'($random(seed)));
      write_bus(reg_addr(ofs_ro_block + 8'(i)), 8'($random(seed)));
      write_bus(reg_addr(ofs_wo_block + 8'(i)), 8'($random(seed)));
    end
    for (int i = 0; i < num_block_regs; i++) begin
      read_bus(reg_addr(ofs_rw_block + 8'(i)));
      read_bus(reg_addr(ofs_ro_block + 8'(i)));
      read_bus(reg_addr(ofs_wo_block + 8'(i)));
    end
    write_bus(reg_addr(ofs_shared), 8'($random(seed)));
    read_bus(reg_addr(ofs_shared));
    repeat (3) write_bus(reg_addr(ofs_user), 8'($random(seed)));
    read_bus(reg_addr(ofs_user));

    // Indirect array through the pointer, two distinct entries
    idx_a = 8'($random(seed));
    idx_b = idx_a ^ 8'h05;
    write_bus(reg_addr(ofs_addr_reg), idx_a);
    write_bus(reg_addr(ofs_indirect), 8'($random(seed)));
    write_bus(reg_addr(ofs_addr_reg), idx_b);
    write_bus(reg_addr(ofs_indirect), 8'($random(seed)));
    write_bus(reg_addr(ofs_addr_reg), idx_a);
    read_bus(reg_addr(ofs_indirect));
    write_bus(reg_addr(ofs_addr_reg), idx_b);
    read_bus(reg_addr(ofs_indirect));

    // Memory window and unmapped space
    for (int i = 0; i < 8; i++) begin
      mem_ofs[i] = 8'($random(seed));
      write_bus({mem_base[15:8], mem_ofs[i]}, 8'($random(seed)));
    end
    for (int i = 0; i < 8; i++) begin
      read_bus({mem_base[15:8], mem_ofs[i]});
    end
    read_bus(16'h0000);
    read_bus(16'h1000);
    read_bus(16'h101C);
    read_bus(16'h2000);

    // Arbitration
    check_idle_starts(6);
    bus_transfer(2'b11, 1'b0, reg_addr(ofs_user), 8'h00, 0);
    bus_transfer(2'b10, 1'b0, reg_addr(ofs_user), 8'h00, 0);
    bus_transfer(2'b01, 1'b0, reg_addr(ofs_user), 8'h00, 0);

    // Burst stretch commits once and delays the next start
    write_bus(reg_addr(ofs_user), 8'($random(seed)));
    bus_transfer(2'b01, 1'b1, reg_addr(ofs_user), 8'($random(seed)), 2);
    check_timing(last_gap == 3, "single beat slot not 3 cycles long");
    read_bus(reg_addr(ofs_user));
    check_timing(last_gap == 5, "burst slot not stretched by exactly 2 cycles");

    bound_errors = dut_i.assertions_i.fail_count;
    $display("Error counts: data %0d, arbitration %0d, timing %0d, response %0d, bound %0d",
             data_errors, arb_errors, timing_errors, resp_errors, bound_errors);
    if (data_errors + arb_errors + timing_errors + resp_errors + bound_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: dv/xbus_subsys_assertions.sv
/* Concurrent checks on xbus arbitration, phase order and the read data
   enable. Bound into the subsystem top, failures go through $error. */
`timescale 1ns/1ps

module xbus_subsys_assertions (
  input logic                 xbus_clock,
  input logic                 xbus_reset,
  input logic [1:0]           request,
  input logic                 start,
  input logic [1:0]           grant,
  input logic                 read,
  input logic                 write,
  input logic                 take_write,
  input logic                 data_oe,
  input xbus_pkg::bus_phase_e phase
);

  import xbus_pkg::*;

  int fail_count = 0;

  // ----------------------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------------------
  grant_not_both: assert property (@(posedge xbus_clock) disable iff (xbus_reset)
    grant != 2'b11)
    else begin
      $error("both masters granted at once");
      fail_count++;
    end

  // Grant settles mid start cycle, so it is seen together with start
  grant_with_start: assert property (@(posedge xbus_clock) disable iff (xbus_reset)
    grant != 2'b00 |-> start)
    else begin
      $error("grant given outside a start cycle");
      fail_count++;
    end

  master0_first: assert property (@(posedge xbus_clock) disable iff (xbus_reset)
    start && request[0] |-> grant == 2'b01)
    else begin
      $error("master 0 requested but was not granted");
      fail_count++;
    end

  master1_alone: assert property (@(posedge xbus_clock) disable iff (xbus_reset)
    start && request == 2'b10 |-> grant == 2'b10)
    else begin
      $error("master 1 requested alone but was not granted");
      fail_count++;
    end

  // Empty slot gives a no-op cycle, then a new start
  noop_restart: assert property (@(posedge xbus_clock) disable iff (xbus_reset)
    start && request == 2'b00 |=> !start ##1 start)
    else begin
      $error("start did not repeat every second cycle while idle");
      fail_count++;
    end

  start_in_reset: assert property (@(posedge xbus_clock) xbus_reset |-> !start)
    else begin
      $error("start pulsed during reset");
      fail_count++;
    end

  // ----------------------------------------------------------------------
  // Phase order and read enable
  // ----------------------------------------------------------------------
  // Granted master drives the direction only in the arbiter's address phase
  rw_in_addr_phase: assert property (@(posedge xbus_clock) disable iff (xbus_reset)
    (read || write) |-> phase == PH_ADDR)
    else begin
      $error("read or write driven outside the address phase");
      fail_count++;
    end

  no_oe_on_write: assert property (@(posedge xbus_clock) disable iff (xbus_reset)
    (write || take_write) |-> !data_oe)
    else begin
      $error("read data enabled during a write");
      fail_count++;
    end

endmodule

bind xbus_subsys xbus_subsys_assertions assertions_i (
  .xbus_clock (xbus_clock),
  .xbus_reset (xbus_reset),
  .request    (request),
  .start      (start),
  .grant      (grant),
  .read       (read),
  .write      (write),
  .take_write (take_write),
  .data_oe    (data_oe),
  .phase      (arbiter_i.state)
);

// File: src/xbus_subsys.sv
/* xbus slave subsystem top. Joins the arbiter, slave port and register
   file on the outside bus. Wait and error are tied low. */
`timescale 1ns/1ps

module xbus_subsys (
  input  logic                            xbus_clock,
  input  logic                            xbus_reset,
  input  logic [1:0]                      request,
  input  logic [xbus_pkg::addr_width-1:0] addr,
  input  logic                            read,
  input  logic                            write,
  input  logic                            bip,
  input  logic [xbus_pkg::data_width-1:0] data_w,
  output logic                            start,
  output logic [1:0]                      grant,
  output logic [xbus_pkg::data_width-1:0] data_r,
  output logic                            data_oe,
  output logic                            slave_wait,
  output logic                            error
);

  import xbus_pkg::*;

  logic       addr_phase;
  logic       data_phase;
  reg_sel_e   sel;
  logic [2:0] index;
  logic [7:0] offset;
  logic       take_read;
  logic       take_write;

  // No stalls and no error responses from this slave
  assign slave_wait = 1'b0;
  assign error      = 1'b0;

  xbus_arbiter arbiter_i (
    .xbus_clock (xbus_clock),
    .xbus_reset (xbus_reset),
    .request    (request),
    .bip        (bip),
    .start      (start),
    .grant      (grant),
    .addr_phase (addr_phase),
    .data_phase (data_phase)
  );

  xbus_slave_port slave_port_i (
    .xbus_clock (xbus_clock),
    .xbus_reset (xbus_reset),
    .addr       (addr),
    .read       (read),
    .write      (write),
    .addr_phase (addr_phase),
    .data_phase (data_phase),
    .sel        (sel),
    .index      (index),
    .offset     (offset),
    .take_read  (take_read),
    .take_write (take_write),
    .data_oe    (data_oe)
  );

  xbus_reg_file reg_file_i (
    .xbus_clock (xbus_clock),
    .xbus_reset (xbus_reset),
    .sel        (sel),
    .index      (index),
    .offset     (offset),
    .addr       (addr[7:0]),
    .addr_phase (addr_phase),
    .take_read  (take_read),
    .take_write (take_write),
    .data_w     (data_w),
    .data_r     (data_r)
  );

endmodule

// File: src/xbus_reg_file.sv
/* xbus register file. Holds the pointer, config, counter, shared, indirect
   and block registers, returns read data from the latched region select
   and commits writes at the end of the first data cycle. */
`timescale 1ns/1ps

module xbus_reg_file (
  input  logic                            xbus_clock,
  input  logic                            xbus_reset,
  input  xbus_pkg::reg_sel_e              sel,
  input  logic [2:0]                      index,
  input  logic [7:0]                      offset,
  input  logic [7:0]                      addr,
  input  logic                            addr_phase,
  input  logic                            take_read,
  input  logic                            take_write,
  input  logic [xbus_pkg::data_width-1:0] data_w,
  output logic [xbus_pkg::data_width-1:0] data_r
);

  import xbus_pkg::*;

  logic [data_width-1:0] addr_reg;
  logic [3:0]            cfg_rsvd;
  logic [1:0]            cfg_kind;
  logic [1:0]            cfg_dest;
  logic [data_width-1:0] user_cnt;
  logic [data_width-1:0] shared_wr;
  logic [data_width-1:0] ind_regs [num_indirect];
  logic [data_width-1:0] rw_regs [num_block_regs];
  logic [data_width-1:0] wo_regs [num_block_regs];
  logic [data_width-1:0] rd_value;

  logic [7:0]            mem_addr;
  logic [data_width-1:0] mem_wdata;
  logic                  mem_we;
  logic [data_width-1:0] mem_rdata;

  logic [blk_idx_width-1:0] blk_idx;
  logic [ind_idx_width-1:0] ind_idx;

  assign blk_idx = index[blk_idx_width-1:0];
  assign ind_idx = addr_reg[ind_idx_width-1:0];

  // ----------------------------------------------------------------------
  // Register writes
  // ----------------------------------------------------------------------
  always_ff @(posedge xbus_clock or posedge xbus_reset) begin
    if (xbus_reset) begin
      addr_reg                       <= rst_addr_reg;
      {cfg_rsvd, cfg_kind, cfg_dest} <= rst_config;
      user_cnt                       <= '0;
      shared_wr                      <= '0;
      for (int i = 0; i < num_indirect; i++) begin
        ind_regs[i] <= '0;
      end
      for (int i = 0; i < num_block_regs; i++) begin
        rw_regs[i] <= rst_rw;
        wo_regs[i] <= rst_wo;
      end
    end else if (take_write) begin
      case (sel)
        SEL_ADDR_REG: addr_reg <= data_w;
        SEL_CONFIG:   {cfg_rsvd, cfg_kind, cfg_dest} <= data_w;
        // Counts writes, data is ignored
        SEL_USER:     user_cnt <= user_cnt + 1'b1;
        SEL_SHARED:   shared_wr <= data_w;
        SEL_INDIRECT: ind_regs[ind_idx] <= data_w;
        SEL_RW:       rw_regs[blk_idx] <= data_w;
        SEL_WO:       wo_regs[blk_idx] <= data_w;
        // RO block, memory and unmapped space take no register write here
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------
  always_comb begin
    case (sel)
      SEL_ADDR_REG: rd_value = addr_reg;
      SEL_CONFIG:   rd_value = {cfg_rsvd, cfg_kind, cfg_dest};
      SEL_USER:     rd_value = user_cnt;
      // Read half is fixed, the written half is never visible
      SEL_SHARED:   rd_value = rst_shared_rd;
      SEL_INDIRECT: rd_value = ind_regs[ind_idx];
      SEL_RW:       rd_value = rw_regs[blk_idx];
      // Read-only block stays at its reset value
      SEL_RO:       rd_value = rst_ro;
      SEL_MEM:      rd_value = mem_rdata;
      default:      rd_value = '0;
    endcase
  end

  assign data_r = take_read ? rd_value : '0;

  // Bus address during the address phase so the sync read is ready in
  // the first data cycle
  assign mem_addr  = addr_phase ? addr : offset;
  assign mem_wdata = data_w;
  assign mem_we    = take_write && (sel == SEL_MEM);

  xbus_scratch_mem mem_i (
    .xbus_clock (xbus_clock),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_we     (mem_we),
    .mem_rdata  (mem_rdata)
  );

endmodule

// File: src/xbus_slave_port.sv
/* xbus slave port. Decodes the address phase into a register region and
   index, latches the transfer direction and drives the data phase strobes
   and the read data enable. */
`timescale 1ns/1ps

module xbus_slave_port (
  input  logic                           xbus_clock,
  input  logic                           xbus_reset,
  input  logic [xbus_pkg::addr_width-1:0] addr,
  input  logic                           read,
  input  logic                           write,
  input  logic                           addr_phase,
  input  logic                           data_phase,
  output xbus_pkg::reg_sel_e             sel,
  output logic [2:0]                     index,
  output logic [7:0]                     offset,
  output logic                           take_read,
  output logic                           take_write,
  output logic                           data_oe
);

  import xbus_pkg::*;

  reg_sel_e   sel_d;
  logic [2:0] index_d;
  logic       rd_dir;
  logic       wr_pending;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  always_comb begin
    sel_d   = SEL_NONE;
    index_d = {1'b0, addr[1:0]};
    if (addr[15:8] == mem_base[15:8]) begin
      sel_d = SEL_MEM;
    end else if (addr[15:8] == reg_base[15:8]) begin
      // Single registers first, then the 4-entry blocks
      if (addr[7:0] == ofs_addr_reg) begin
        sel_d = SEL_ADDR_REG;
      end else if (addr[7:0] == ofs_config) begin
        sel_d = SEL_CONFIG;
      end else if (addr[7:0] == ofs_user) begin
        sel_d = SEL_USER;
      end else if (addr[7:0] == ofs_shared) begin
        sel_d = SEL_SHARED;
      end else if (addr[7:0] == ofs_indirect) begin
        sel_d = SEL_INDIRECT;
      end else if (addr[7:2] == ofs_rw_block[7:2]) begin
        sel_d = SEL_RW;
      end else if (addr[7:2] == ofs_ro_block[7:2]) begin
        sel_d = SEL_RO;
      end else if (addr[7:2] == ofs_wo_block[7:2]) begin
        sel_d = SEL_WO;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Address phase capture
  // ----------------------------------------------------------------------
  always_ff @(posedge xbus_clock or posedge xbus_reset) begin
    if (xbus_reset) begin
      sel        <= SEL_NONE;
      rd_dir     <= 1'b0;
      wr_pending <= 1'b0;
    end else if (addr_phase) begin
      sel        <= sel_d;
      rd_dir     <= read && !write;
      wr_pending <= write && !read;
    end else if (data_phase) begin
      // Write strobe lasts one beat, even when bip stretches the phase
      wr_pending <= 1'b0;
    end
  end

  always_ff @(posedge xbus_clock) begin
    if (addr_phase) begin
      index  <= index_d;
      offset <= addr[7:0];
    end
  end

  assign take_read  = data_phase && rd_dir;
  assign take_write = data_phase && wr_pending;
  assign data_oe    = take_read;

endmodule

// File: src/xbus_arbiter.sv
/* Two-master xbus arbiter. Steps the bus through start, address and data
   phases and grants the slot to master 0 first, else master 1. */
`timescale 1ns/1ps

module xbus_arbiter (
  input  logic       xbus_clock,
  input  logic       xbus_reset,
  input  logic [1:0] request,
  input  logic       bip,
  output logic       start,
  output logic [1:0] grant,
  output logic       addr_phase,
  output logic       data_phase
);

  import xbus_pkg::*;

  bus_phase_e state;
  bus_phase_e state_nxt;

  // ----------------------------------------------------------------------
  // Phase sequencing
  // ----------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      PH_RESET: state_nxt = PH_START;
      // Grant settled on the falling edge of this cycle
      PH_START: state_nxt = (grant != 2'b00) ? PH_ADDR : PH_NOOP;
      // Nobody asked, so open another slot
      PH_NOOP:  state_nxt = PH_START;
      PH_ADDR:  state_nxt = PH_DATA;
      // Burst keeps the data phase open
      PH_DATA:  state_nxt = bip ? PH_DATA : PH_START;
      default:  state_nxt = PH_RESET;
    endcase
  end

  always_ff @(posedge xbus_clock or posedge xbus_reset) begin
    if (xbus_reset) begin
      state <= PH_RESET;
    end else begin
      state <= state_nxt;
    end
  end

  assign start      = (state == PH_START);
  assign addr_phase = (state == PH_ADDR);
  assign data_phase = (state == PH_DATA);

  // ----------------------------------------------------------------------
  // Grant, sampled mid-cycle while start is high
  // ----------------------------------------------------------------------
  always_ff @(negedge xbus_clock or posedge xbus_reset) begin
    if (xbus_reset) begin
      grant <= 2'b00;
    end else if (start && request[0]) begin
      grant <= 2'b01;
    end else if (start && request[1]) begin
      grant <= 2'b10;
    end else begin
      // Drops back to zero halfway through the address phase
      grant <= 2'b00;
    end
  end

endmodule

// File: src/xbus_scratch_mem.sv
/* 256-byte scratch memory behind the register file. Writes on we, and the
   read data is registered so it shows one cycle after the address. */
`timescale 1ns/1ps

module xbus_scratch_mem (
  input  logic       xbus_clock,
  input  logic [7:0] mem_addr,
  input  logic [7:0] mem_wdata,
  input  logic       mem_we,
  output logic [7:0] mem_rdata
);

  logic [7:0] mem [256];

  always_ff @(posedge xbus_clock) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    // Old data on a same-address write
    mem_rdata <= mem[mem_addr];
  end

endmodule

// File: src/xbus_pkg.sv
/* Shared definitions for the xbus slave subsystem. Holds the bus widths,
   the register address map, register reset values and the phase and
   region enums. Modules pull these in with a wildcard import. */
package xbus_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int addr_width = 16;
  localparam int data_width = 8;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  localparam logic [addr_width-1:0] reg_base = 16'h1000;
  localparam logic [addr_width-1:0] mem_base = 16'h1100;

  // Offsets inside the register window
  localparam logic [7:0] ofs_addr_reg = 8'h08;
  localparam logic [7:0] ofs_config   = 8'h09;
  localparam logic [7:0] ofs_user     = 8'h0A;
  localparam logic [7:0] ofs_shared   = 8'h0B;
  localparam logic [7:0] ofs_indirect = 8'h0C;
  localparam logic [7:0] ofs_rw_block = 8'h10;
  localparam logic [7:0] ofs_ro_block = 8'h14;
  localparam logic [7:0] ofs_wo_block = 8'h18;

  localparam int num_block_regs = 4;
  localparam int num_indirect   = 8;
  localparam int blk_idx_width  = $clog2(num_block_regs);
  localparam int ind_idx_width  = $clog2(num_indirect);

  // ----------------------------------------------------------------------
  // Reset values
  // ----------------------------------------------------------------------
  localparam logic [data_width-1:0] rst_addr_reg  = 8'h01;
  localparam logic [data_width-1:0] rst_config    = 8'hF0;  // reserved nibble is ones
  localparam logic [data_width-1:0] rst_shared_rd = 8'hA5;
  localparam logic [data_width-1:0] rst_rw        = 8'h5A;
  localparam logic [data_width-1:0] rst_ro        = 8'hA5;
  localparam logic [data_width-1:0] rst_wo        = 8'h55;

  // Arbiter phase
  typedef enum logic [2:0] {
    PH_RESET, PH_START, PH_NOOP, PH_ADDR, PH_DATA
  } bus_phase_e;

  // Decoded register region
  typedef enum logic [3:0] {
    SEL_NONE, SEL_ADDR_REG, SEL_CONFIG, SEL_USER, SEL_SHARED,
    SEL_INDIRECT, SEL_RW, SEL_RO, SEL_WO, SEL_MEM
  } reg_sel_e;

endpackage
